/* rtl/trigger_pkg.sv */
// Trigger front end shared definitions

package trigger_pkg;

    // --------------------------------------------------
    // field widths
    // --------------------------------------------------

    localparam int trig_num_w  = 24; // trigger number, starts at 1
    localparam int timestamp_w = 44; // 40 MHz ticks since last timestamp reset
    localparam int trig_type_w = 5;  // trigger-type code

    // --------------------------------------------------
    // record FIFO and credit port
    // --------------------------------------------------

    localparam int fifo_depth  = 16; // records held between receivers and readout
    localparam int max_credits = 4;  // records the consumer can take unasked

    // derived sizes
    localparam int fifo_ptr_w = $clog2(fifo_depth);
    localparam int fifo_cnt_w = $clog2(fifo_depth + 1); // holds 0..fifo_depth
    localparam int credit_w   = $clog2(max_credits + 1);

    // --------------------------------------------------
    // codes
    // --------------------------------------------------

    // which receiver built the record
    localparam logic src_ttc   = 1'b0;
    localparam logic src_pulse = 1'b1;

    // front panel types, kept clear of the TTC programmed types
    localparam logic [trig_type_w-1:0] type_pulse_short = 5'b01000;
    localparam logic [trig_type_w-1:0] type_pulse_long  = 5'b01001;

    // one trigger as it leaves the board, 74 bits, msb first
    typedef struct packed {
        logic                   src;       // src_ttc or src_pulse
        logic [trig_type_w-1:0] trig_type; // programmed or pulse class
        logic [trig_num_w-1:0]  trig_num;  // per-source sequence number
        logic [timestamp_w-1:0] timestamp; // time of the leading edge
    } trig_record_t;

endpackage

/* rtl/ttc_trigger_receiver.sv */
`timescale 1ns/1ns
// Backplane trigger receiver

module ttc_trigger_receiver (
    // clock and reset
    input  logic ttc_clk,
    input  logic reset,

    // TTC channel B commands
    input  logic rst_trigger_num,       // restart numbering at 1
    input  logic rst_trigger_timestamp, // reload time base to 0

    // trigger in
    input  logic                                ttc_trigger, // backplane trigger line
    input  logic [trigger_pkg::trig_type_w-1:0] trig_type,   // programmed type

    // arbiter side
    input  logic                      grant,
    output logic                      req,    // record waiting
    output trigger_pkg::trig_record_t record,

    // status
    output logic [trigger_pkg::timestamp_w-1:0] timestamp, // board time base
    output logic [trigger_pkg::trig_num_w-1:0]  trig_num,  // last number handed out
    output logic                                error_trig_rate // sticky
);

    import trigger_pkg::*;

    logic                  trigger_q; // previous sample of ttc_trigger
    logic                  trig_edge;
    logic                  pending;   // record still not taken this cycle
    logic [trig_num_w-1:0] num_base;

    assign trig_edge = ttc_trigger & ~trigger_q; // high now, low last sample
    assign pending   = req & ~grant;             // a grant frees the slot this cycle
    assign num_base  = rst_trigger_num ? '0 : trig_num;

    // --------------------------------------------------
    // time base
    // --------------------------------------------------

    // reads 0 the first cycle out of reset, then +1 per tick
    always_ff @(posedge ttc_clk) begin
        if (reset || rst_trigger_timestamp) begin
            timestamp <= '0;
        end else begin
            timestamp <= timestamp + 1'b1;
        end
    end

    // --------------------------------------------------
    // edge detect, numbering, request
    // --------------------------------------------------

    always_ff @(posedge ttc_clk) begin
        if (reset) begin
            trigger_q       <= 1'b0;
            req             <= 1'b0;
            trig_num        <= '0;
            error_trig_rate <= 1'b0;
        end else begin
            trigger_q <= ttc_trigger;
            if (rst_trigger_num) trig_num <= '0;
            if (grant) req <= 1'b0; // written into the FIFO this cycle
            if (trig_edge) begin
                if (pending) begin
                    error_trig_rate <= 1'b1; // dropped, no number used
                end else begin
                    req      <= 1'b1;
                    trig_num <= num_base + 1'b1;
                end
            end
        end
    end

    // record payload, loaded with the accepted edge
    always_ff @(posedge ttc_clk) begin
        if (trig_edge && !pending) begin
            record.src       <= src_ttc;
            record.trig_type <= trig_type;
            record.trig_num  <= num_base + 1'b1;
            record.timestamp <= timestamp; // value in the detection cycle
        end
    end

    // offered record stays up until the arbiter takes it
    a_req_held : assert property (@(posedge ttc_clk) disable iff (reset)
        req && !grant |=> req);

endmodule

/* rtl/pulse_trigger_receiver.sv */
`timescale 1ns/1ns
// Front panel pulse trigger receiver

module pulse_trigger_receiver (
    // clock and reset
    input  logic ttc_clk,
    input  logic reset,

    input  logic rst_trigger_num, // TTC channel B, restart numbering

    // pulse in
    input  logic                                ext_trigger,           // front panel line
    input  logic                                accept_pulse_triggers, // enable
    input  logic [3:0]                          fp_trig_width,         // short/long limit
    input  logic [trigger_pkg::timestamp_w-1:0] timestamp,             // from TTC receiver

    // arbiter side
    input  logic                      grant,
    output logic                      req,
    output trigger_pkg::trig_record_t record,

    // status
    output logic [trigger_pkg::trig_num_w-1:0] pulse_trig_num, // last pulse number
    output logic                               error_pulse_drop // sticky
);

    import trigger_pkg::*;

    logic                   ext_q;          // previous sample
    logic                   lead_edge;
    logic                   trail_edge;
    logic                   pulse_done;     // finished and accepted
    logic                   pending;
    logic [4:0]             width_cnt;      // high samples, saturates at 31
    logic [timestamp_w-1:0] lead_timestamp; // time of first high sample
    logic [trig_num_w-1:0]  num_base;
    logic [trig_type_w-1:0] pulse_type;

    assign lead_edge  = ext_trigger & ~ext_q;
    assign trail_edge = ~ext_trigger & ext_q; // first low sample
    assign pulse_done = trail_edge & accept_pulse_triggers;
    assign pending    = req & ~grant;
    assign num_base   = rst_trigger_num ? '0 : pulse_trig_num;

    // anything wider than the programmed limit counts as long
    assign pulse_type = (width_cnt > {1'b0, fp_trig_width}) ? type_pulse_long
                                                            : type_pulse_short;

    // --------------------------------------------------
    // width measurement
    // --------------------------------------------------

    always_ff @(posedge ttc_clk) begin
        if (reset) begin
            ext_q     <= 1'b0;
            width_cnt <= '0;
        end else begin
            ext_q <= ext_trigger;
            if (lead_edge) begin
                width_cnt <= 5'd1;
            end else if (ext_trigger && width_cnt != 5'h1f) begin
                width_cnt <= width_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge ttc_clk) begin
        if (lead_edge) lead_timestamp <= timestamp;
    end

    // --------------------------------------------------
    // numbering and request
    // --------------------------------------------------

    always_ff @(posedge ttc_clk) begin
        if (reset) begin
            req              <= 1'b0;
            pulse_trig_num   <= '0;
            error_pulse_drop <= 1'b0;
        end else begin
            if (rst_trigger_num) pulse_trig_num <= '0;
            if (grant) req <= 1'b0;
            if (pulse_done) begin
                if (pending) begin
                    error_pulse_drop <= 1'b1; // slot busy, pulse lost
                end else begin
                    req            <= 1'b1;
                    pulse_trig_num <= num_base + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge ttc_clk) begin
        if (pulse_done && !pending) begin
            record.src       <= src_pulse;
            record.trig_type <= pulse_type;
            record.trig_num  <= num_base + 1'b1;
            record.timestamp <= lead_timestamp;
        end
    end

    // same hold rule as the TTC side
    a_req_held : assert property (@(posedge ttc_clk) disable iff (reset)
        req && !grant |=> req);

endmodule

/* rtl/trigger_arbiter.sv */
`timescale 1ns/1ns
// Round-robin record arbiter

module trigger_arbiter (
    input  logic ttc_clk,
    input  logic reset,

    // TTC receiver
    input  logic                      ttc_req,
    input  trigger_pkg::trig_record_t ttc_record,
    output logic                      ttc_grant,

    // pulse receiver
    input  logic                      pulse_req,
    input  trigger_pkg::trig_record_t pulse_record,
    output logic                      pulse_grant,

    // FIFO write port
    input  logic                      full,
    output logic                      wr_en,
    output trigger_pkg::trig_record_t wr_record
);

    import trigger_pkg::*;

    logic prio_pulse; // pulse side wins a tie

    // --------------------------------------------------
    // grant
    // --------------------------------------------------

    // nothing moves while the FIFO is full
    assign ttc_grant   = ttc_req & ~full & (~pulse_req | ~prio_pulse);
    assign pulse_grant = pulse_req & ~full & (~ttc_req | prio_pulse);

    assign wr_en     = ttc_grant | pulse_grant;
    assign wr_record = pulse_grant ? pulse_record : ttc_record; // same-cycle write

    // priority goes to the side that just lost its turn
    always_ff @(posedge ttc_clk) begin
        if (reset) begin
            prio_pulse <= 1'b0;
        end else if (wr_en) begin
            prio_pulse <= ttc_grant;
        end
    end

    a_one_grant : assert property (@(posedge ttc_clk) disable iff (reset)
        !(ttc_grant && pulse_grant));

    a_grant_req : assert property (@(posedge ttc_clk) disable iff (reset)
        (ttc_grant |-> ttc_req) and (pulse_grant |-> pulse_req));

endmodule

/* rtl/trigger_record_fifo.sv */
`timescale 1ns/1ns
// Trigger record FIFO with credit output

module trigger_record_fifo (
    input  logic ttc_clk,
    input  logic reset,

    // write side, from arbiter
    input  logic                      wr_en,
    input  trigger_pkg::trig_record_t wr_record,
    output logic                      full,

    // read side, off-board
    input  logic                      credit_return, // one credit per high cycle
    output logic                      out_valid,     // one record per high cycle
    output trigger_pkg::trig_record_t out_record
);

    import trigger_pkg::*;

    trig_record_t          mem [fifo_depth]; // record storage
    logic [fifo_ptr_w-1:0] wr_ptr;
    logic [fifo_ptr_w-1:0] rd_ptr;
    logic [fifo_cnt_w-1:0] count;   // occupancy
    logic [credit_w-1:0]   credits; // records the consumer can still take

    // wrap for any depth, not just powers of two
    function automatic logic [fifo_ptr_w-1:0] ptr_next(input logic [fifo_ptr_w-1:0] ptr);
        return (ptr == fifo_ptr_w'(fifo_depth - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign full       = (count == fifo_cnt_w'(fifo_depth));
    assign out_valid  = (count != '0) && (credits != '0); // send as soon as allowed
    assign out_record = mem[rd_ptr];

    // --------------------------------------------------
    // storage and pointers
    // --------------------------------------------------

    always_ff @(posedge ttc_clk) begin
        if (wr_en) mem[wr_ptr] <= wr_record;
    end

    always_ff @(posedge ttc_clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) wr_ptr <= ptr_next(wr_ptr);
            if (out_valid) rd_ptr <= ptr_next(rd_ptr);
            case ({wr_en, out_valid})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count; // idle or pass-through
            endcase
        end
    end

    // --------------------------------------------------
    // credit counter
    // --------------------------------------------------

    always_ff @(posedge ttc_clk) begin
        if (reset) begin
            credits <= credit_w'(max_credits); // consumer starts with a full window
        end else begin
            case ({credit_return, out_valid})
                2'b10:   credits <= credits + 1'b1;
                2'b01:   credits <= credits - 1'b1;
                default: credits <= credits;
            endcase
        end
    end

    // arbiter has to honor full
    a_no_write_full : assert property (@(posedge ttc_clk) disable iff (reset)
        wr_en |-> !full);

    // consumer must not return more than it was sent
    a_credit_limit : assert property (@(posedge ttc_clk) disable iff (reset)
        credits <= max_credits);

    a_valid_credit : assert property (@(posedge ttc_clk) disable iff (reset)
        out_valid |-> credits != '0);

endmodule

/* rtl/trigger_top.sv */
`timescale 1ns/1ns
// Trigger front end top level

module trigger_top (
    input  logic ttc_clk, // 40 MHz
    input  logic reset,

    input  logic rst_trigger_num,       // TTC channel B
    input  logic rst_trigger_timestamp, // TTC channel B

    // trigger inputs
    input  logic                                ttc_trigger, // backplane
    input  logic                                ext_trigger, // front panel
    input  logic                                accept_pulse_triggers,
    input  logic [trigger_pkg::trig_type_w-1:0] trig_type,
    input  logic [3:0]                          fp_trig_width,

    // record output, credit flow control
    input  logic                      credit_return,
    output logic                      out_valid,
    output trigger_pkg::trig_record_t out_record,

    // status
    output logic [trigger_pkg::trig_num_w-1:0]  trig_num,
    output logic [trigger_pkg::timestamp_w-1:0] trig_timestamp, // running time base
    output logic [trigger_pkg::trig_num_w-1:0]  pulse_trig_num,
    output logic                                fifo_full,
    output logic                                error_trig_rate,
    output logic                                error_pulse_drop
);

    import trigger_pkg::*;

    // receivers to arbiter
    logic         ttc_req;
    logic         ttc_grant;
    trig_record_t ttc_record;
    logic         pulse_req;
    logic         pulse_grant;
    trig_record_t pulse_record;

    // arbiter to FIFO
    logic         wr_en;
    trig_record_t wr_record;

    ttc_trigger_receiver ttc_trigger_receiver_i (
        .ttc_clk               (ttc_clk),
        .reset                 (reset),
        .rst_trigger_num       (rst_trigger_num),
        .rst_trigger_timestamp (rst_trigger_timestamp),
        .ttc_trigger           (ttc_trigger),
        .trig_type             (trig_type),
        .grant                 (ttc_grant),
        .req                   (ttc_req),
        .record                (ttc_record),
        .timestamp             (trig_timestamp), // also feeds pulse side
        .trig_num              (trig_num),
        .error_trig_rate       (error_trig_rate)
    );

    pulse_trigger_receiver pulse_trigger_receiver_i (
        .ttc_clk               (ttc_clk),
        .reset                 (reset),
        .rst_trigger_num       (rst_trigger_num),
        .ext_trigger           (ext_trigger),
        .accept_pulse_triggers (accept_pulse_triggers),
        .fp_trig_width         (fp_trig_width),
        .timestamp             (trig_timestamp),
        .grant                 (pulse_grant),
        .req                   (pulse_req),
        .record                (pulse_record),
        .pulse_trig_num        (pulse_trig_num),
        .error_pulse_drop      (error_pulse_drop)
    );

    trigger_arbiter trigger_arbiter_i (
        .ttc_clk      (ttc_clk),
        .reset        (reset),
        .ttc_req      (ttc_req),
        .ttc_record   (ttc_record),
        .ttc_grant    (ttc_grant),
        .pulse_req    (pulse_req),
        .pulse_record (pulse_record),
        .pulse_grant  (pulse_grant),
        .full         (fifo_full),
        .wr_en        (wr_en),
        .wr_record    (wr_record)
    );

    trigger_record_fifo trigger_record_fifo_i (
        .ttc_clk       (ttc_clk),
        .reset         (reset),
        .wr_en         (wr_en),
        .wr_record     (wr_record),
        .full          (fifo_full),
        .credit_return (credit_return),
        .out_valid     (out_valid),
        .out_record    (out_record)
    );

endmodule

/* tests/trigger_model.svh */
// Trigger front end reference model

`ifndef TRIGGER_MODEL_SVH
`define TRIGGER_MODEL_SVH

// expected records, one queue per source since arbitration order is free
trig_record_t exp_ttc_q[$];
trig_record_t exp_pulse_q[$];

logic [timestamp_w-1:0] model_ts;        // time base during the current cycle
logic [trig_num_w-1:0]  model_ttc_num;   // last TTC number handed out
logic [trig_num_w-1:0]  model_pulse_num; // last pulse number handed out
logic [timestamp_w-1:0] model_lead_ts;   // leading edge time of the open pulse
int                     model_width;     // high samples of the open pulse
logic                   model_rate_err;  // sticky, a TTC edge was dropped
int                     outstanding;     // records sent minus credits returned

// --------------------------------------------------
// record builders
// --------------------------------------------------

function automatic void push_ttc(input logic [trig_type_w-1:0] tt);
    trig_record_t rec;
    model_ttc_num = model_ttc_num + 1'b1;
    rec.src       = src_ttc;
    rec.trig_type = tt;
    rec.trig_num  = model_ttc_num;
    rec.timestamp = model_ts; // value of the detection cycle
    exp_ttc_q.push_back(rec);
endfunction

// short up to and including the limit, long above it
function automatic void push_pulse(input logic [3:0] limit);
    trig_record_t rec;
    model_pulse_num = model_pulse_num + 1'b1;
    rec.src         = src_pulse;
    rec.trig_type   = (model_width > int'(limit)) ? type_pulse_long : type_pulse_short;
    rec.trig_num    = model_pulse_num;
    rec.timestamp   = model_lead_ts;
    exp_pulse_q.push_back(rec);
endfunction

// board reset drops everything queued or stored
function automatic void model_clear();
    exp_ttc_q.delete();
    exp_pulse_q.delete();
    model_ts        = '0;
    model_ttc_num   = '0;
    model_pulse_num = '0;
    model_width     = 0;
    model_rate_err  = 1'b0;
    outstanding     = 0;
endfunction

`endif

/* tests/trigger_tb.sv */
`timescale 1ns/1ns
// Trigger front end testbench

module trigger_tb;

    import trigger_pkg::*;

    `include "trigger_model.svh"

    // DUT inputs
    logic                   ttc_clk;
    logic                   reset;
    logic                   rst_trigger_num;
    logic                   rst_trigger_timestamp;
    logic                   ttc_trigger;
    logic                   ext_trigger;
    logic                   accept_pulse_triggers;
    logic [trig_type_w-1:0] trig_type;
    logic [3:0]             fp_trig_width;
    logic                   credit_return;

    // DUT outputs
    logic                   out_valid;
    trig_record_t           out_record;
    logic [trig_num_w-1:0]  trig_num;
    logic [timestamp_w-1:0] trig_timestamp;
    logic [trig_num_w-1:0]  pulse_trig_num;
    logic                   fifo_full;
    logic                   error_trig_rate;
    logic                   error_pulse_drop;

    integer seed;
    logic   prev_ttc;     // last sampled trigger lines
    logic   prev_ext;
    logic   ttc_block;    // FIFO held full, next TTC record stays pending
    logic   ttc_hold;     // a TTC record is stuck in the receiver
    logic   credit_en;    // consumer hands credits back
    int     credits_owed; // records received, credit not yet returned
    int     credit_wait;
    int     ttc_seen;
    int     pulse_seen;

    trigger_top trigger_top_i (.*);

    initial begin
        ttc_clk = 1'b0;
        forever #5 ttc_clk = ~ttc_clk; // 100 MHz sim clock
    end

    task automatic fail_stop(input string what);
        $display("%s", what);
        $display("RESULT: FAIL");
        $fatal(1, "simulation stopped at the first failure");
    endtask

    function automatic int rand_range(input int lo, input int hi);
        return lo + ({$random(seed)} % (hi - lo + 1));
    endfunction

    // n edges, then 1 ns past the last one
    task automatic tick(input int n);
        repeat (n) @(posedge ttc_clk);
        #1;
    endtask

    // --------------------------------------------------
    // model and output checks, on every edge
    // --------------------------------------------------

    task automatic compare_record(input trig_record_t got);
        trig_record_t exp_rec;
        if (got.src == src_ttc) begin
            assert (exp_ttc_q.size() != 0)
                else fail_stop("TTC record came out with none expected");
            exp_rec = exp_ttc_q.pop_front();
            ttc_seen++;
        end else begin
            assert (exp_pulse_q.size() != 0)
                else fail_stop("pulse record came out with none expected");
            exp_rec = exp_pulse_q.pop_front();
            pulse_seen++;
        end
        assert (got === exp_rec) else fail_stop($sformatf(
            "[ERROR] %0t ns: record %h, expected %h", $time, got, exp_rec));
    endtask

    always @(posedge ttc_clk) begin
        if (reset) begin
            model_clear();
            prev_ttc     = 1'b0;
            prev_ext     = 1'b0;
            ttc_hold     = 1'b0;
            credits_owed = 0;
        end else begin
            assert (error_trig_rate === model_rate_err && error_pulse_drop === 1'b0)
                else fail_stop($sformatf(
                    "[ERROR] %0t ns: error flags rate=%b drop=%b, expected %b 0",
                    $time, error_trig_rate, error_pulse_drop, model_rate_err));
            assert (trig_timestamp === model_ts) else fail_stop($sformatf(
                "[ERROR] %0t ns: timestamp %0d, expected %0d", $time, trig_timestamp, model_ts));
            if (out_valid) begin // one record and one credit per cycle
                outstanding++;
                credits_owed++;
                compare_record(out_record);
            end
            if (credit_return) outstanding--;
            assert (outstanding >= 0 && outstanding <= max_credits) else fail_stop($sformatf(
                "[ERROR] %0t ns: %0d records outstanding, limit %0d", $time, outstanding,
                max_credits));
            if (rst_trigger_num) begin
                model_ttc_num   = '0;
                model_pulse_num = '0;
            end
            if (ttc_trigger && !prev_ttc) begin
                if (ttc_hold) begin
                    model_rate_err = 1'b1; // slot busy, no number used
                end else begin
                    push_ttc(trig_type);
                    if (ttc_block) ttc_hold = 1'b1;
                end
            end
            if (ext_trigger && !prev_ext) begin
                model_lead_ts = model_ts;
                model_width   = 1;
            end else if (ext_trigger) begin
                model_width++;
            end
            if (!ext_trigger && prev_ext && accept_pulse_triggers) push_pulse(fp_trig_width);
            prev_ttc = ttc_trigger;
            prev_ext = ext_trigger;
            model_ts = rst_trigger_timestamp ? '0 : model_ts + 1'b1;
        end
    end

    // consumer, returns credits after a random pause
    always @(posedge ttc_clk) begin
        #1;
        credit_return = 1'b0;
        if (credit_wait > 0) begin
            credit_wait--;
        end else if (!reset && credit_en && credits_owed > 0) begin
            credit_return = 1'b1;
            credits_owed--;
            credit_wait   = rand_range(0, 4);
        end
    end

    // --------------------------------------------------
    // stimulus
    // --------------------------------------------------

    task automatic send_ttc(input logic [trig_type_w-1:0] tt, input int high_cycles);
        trig_type   = tt;
        ttc_trigger = 1'b1;
        tick(high_cycles);
        ttc_trigger = 1'b0;
        tick(1);
    endtask

    task automatic send_pulse(input int width);
        ext_trigger = 1'b1;
        tick(width);
        ext_trigger = 1'b0;
        tick(1);
    endtask

    task automatic wait_for_room(input int max_queued);
        int waited;
        waited = 0;
        while (exp_ttc_q.size() + exp_pulse_q.size() > max_queued) begin
            tick(1);
            waited++;
            if (waited > 2000) fail_stop("timeout while waiting for the record output to drain");
        end
    endtask

    // keeps the FIFO short of full, so nothing is dropped here
    task automatic random_round();
        logic                   do_ttc;
        logic                   do_pulse;
        logic [trig_type_w-1:0] tt;
        int                     tw;
        int                     pw;
        wait_for_room(8);
        do_ttc   = rand_range(0, 3) != 0;
        do_pulse = rand_range(0, 3) != 0;
        tt       = trig_type_w'($random(seed));
        tw       = rand_range(1, 3);
        pw       = rand_range(1, 12);
        fp_trig_width         = 4'($random(seed));
        accept_pulse_triggers = rand_range(0, 3) != 0;
        if (rand_range(0, 15) == 0) begin
            rst_trigger_num = 1'b1;
            tick(1);
            rst_trigger_num = 1'b0;
        end
        if (rand_range(0, 23) == 0) begin
            rst_trigger_timestamp = 1'b1;
            tick(1);
            rst_trigger_timestamp = 1'b0;
        end
        fork
            if (do_ttc) send_ttc(tt, tw);
            if (do_pulse) send_pulse(pw);
        join
        tick(rand_range(3, 6));
    endtask

    initial begin
        int waited;
        seed                  = 32'h14d6;
        reset                 = 1'b1;
        rst_trigger_num       = 1'b0;
        rst_trigger_timestamp = 1'b0;
        ttc_trigger           = 1'b0;
        ext_trigger           = 1'b0;
        accept_pulse_triggers = 1'b1;
        trig_type             = '0;
        fp_trig_width         = 4'd4;
        credit_return         = 1'b0;
        credit_en             = 1'b1;
        credit_wait           = 0;
        ttc_block             = 1'b0;
        ttc_seen              = 0;
        pulse_seen            = 0;
        tick(5);
        reset = 1'b0;
        assert (!out_valid && !fifo_full && !error_trig_rate && !error_pulse_drop)
            else fail_stop($sformatf("[ERROR] %0t ns: outputs not idle after reset", $time));

        repeat (80) random_round();
        wait_for_room(0);

        // numbering restart on both sources
        rst_trigger_num = 1'b1;
        tick(1);
        rst_trigger_num       = 1'b0;
        accept_pulse_triggers = 1'b1;
        fork
            send_ttc(5'd3, 2);
            send_pulse(6);
        join
        tick(4);
        wait_for_room(0);
        assert (trig_num == 1 && pulse_trig_num == 1) else fail_stop($sformatf(
            "[ERROR] %0t ns: numbers %0d %0d after restart, expected 1 1", $time, trig_num,
            pulse_trig_num));

        // --------------------------------------------------
        // back-pressure, credits withheld until full
        // --------------------------------------------------
        credit_en = 1'b0;
        waited    = 0;
        while (!fifo_full) begin
            send_ttc(trig_type_w'($random(seed)), 1);
            tick(2); // record granted before the next look
            waited++;
            if (waited > 40) fail_stop("FIFO never reported full while credits were withheld");
        end
        ttc_block = 1'b1;
        send_ttc(5'd7, 1); // stays pending
        tick(2);
        send_ttc(5'd9, 1); // dropped
        tick(2);
        assert (error_trig_rate && trig_num == model_ttc_num) else fail_stop($sformatf(
            "[ERROR] %0t ns: rate error %b number %0d, expected 1 %0d", $time, error_trig_rate,
            trig_num, model_ttc_num));
        credit_en = 1'b1;
        wait_for_room(0);
        ttc_block = 1'b0;
        ttc_hold  = 1'b0;
        send_ttc(5'd2, 1); // number follows the pending one
        tick(3);
        wait_for_room(0);

        reset = 1'b1;
        tick(5);
        reset = 1'b0;
        assert (!error_trig_rate && !error_pulse_drop && !fifo_full && !out_valid)
            else fail_stop($sformatf("[ERROR] %0t ns: flags not cleared by reset", $time));
        repeat (30) random_round();
        wait_for_room(0);
        tick(5);

        if (ttc_seen > 0 && pulse_seen > 0) begin
            $display("RESULT: PASS");
            $finish;
        end else begin
            fail_stop("no records of one source were seen during the run");
        end
    end

endmodule

/* vlog.f */
+incdir+tests
rtl/trigger_pkg.sv
rtl/ttc_trigger_receiver.sv
rtl/pulse_trigger_receiver.sv
rtl/trigger_arbiter.sv
rtl/trigger_record_fifo.sv
rtl/trigger_top.sv
tests/trigger_tb.sv
